/* build.f */
src/ing_buf_pkg.sv
src/ing_width_adapter.sv
src/ing_pkt_store.sv
src/ing_buf_top.sv
verification/ing_buf_properties.sv
verification/tb_ing_buf.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ingress buffer testbench with Verilator and runs it.
# Exit status is zero only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_ing_buf \
    -Mdir "$BUILD_DIR" -o sim_ing_buf \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_ing_buf" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* src/ing_buf_pkg.sv */
/* Shared widths and payload structs of the ingress buffer.
   BUS_BYTES must be a multiple of IN_BYTES, and at most 8 ports fit the port tag. */

`default_nettype none

package ing_buf_pkg;

    // Bytes per narrow input beat, common to all ports
    localparam int IN_BYTES = 2;

    // Bytes per wide word in the store and on the output
    localparam int BUS_BYTES = 8;

    localparam int BEATS_PER_WORD = BUS_BYTES / IN_BYTES;

    // Width of the source port tag on the output stream
    localparam int PORT_IDX_BITS = 3;

    // One beat on a narrow ingress port
    typedef struct packed {
        logic [IN_BYTES-1:0][7:0] data;
        logic [IN_BYTES-1:0]      keep;
        logic                     last;
    } in_beat_t;

    // One packed word between adapter and store
    typedef struct packed {
        logic [BUS_BYTES-1:0][7:0] data;
        logic [BUS_BYTES-1:0]      keep;
        logic                      last;
    } bus_word_t;

    // One word on the output stream, tagged with its source port
    typedef struct packed {
        logic                      valid;
        logic [BUS_BYTES-1:0][7:0] data;
        logic [BUS_BYTES-1:0]      keep;
        logic                      last;
        logic [PORT_IDX_BITS-1:0]  port;
    } pkt_word_t;

endpackage

`default_nettype wire

/* src/ing_buf_top.sv */
/* Ingress buffer top: one width adapter per port feeding the shared packet store.
   NUM_PORTS is limited to 8 by the port tag; PART_WORDS must be a power of two. */

`default_nettype none

module ing_buf_top #(
    parameter int NUM_PORTS     = 4,
    parameter int PART_WORDS    = 16,
    parameter int PKTS_PER_PART = 8
) (
    input  logic                                   ing_bus,
    input  logic                                   arst_n,
    input  logic [NUM_PORTS-1:0]                   in_valid,
    input  ing_buf_pkg::in_beat_t [NUM_PORTS-1:0]  in_beat,
    output logic [NUM_PORTS-1:0]                   in_ready,
    output ing_buf_pkg::pkt_word_t                 pkt_out,
    output logic [NUM_PORTS-1:0]                   overflow
);

    //////////////////////////////////////////////////////////////////////
    // Adapter to store wiring
    //////////////////////////////////////////////////////////////////////

    logic [NUM_PORTS-1:0]                   word_valid;
    ing_buf_pkg::bus_word_t [NUM_PORTS-1:0] word;
    logic [NUM_PORTS-1:0]                   grant;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        ing_width_adapter adapter_i (
            .ing_bus    (ing_bus),
            .arst_n     (arst_n),
            .in_valid   (in_valid[p]),
            .in_beat    (in_beat[p]),
            .in_ready   (in_ready[p]),
            .grant      (grant[p]),
            .word_valid (word_valid[p]),
            .word       (word[p])
        );
    end

    // Shared store and output scheduler
    ing_pkt_store #(
        .NUM_PORTS     (NUM_PORTS),
        .PART_WORDS    (PART_WORDS),
        .PKTS_PER_PART (PKTS_PER_PART)
    ) store_i (
        .ing_bus    (ing_bus),
        .arst_n     (arst_n),
        .word_valid (word_valid),
        .word       (word),
        .grant      (grant),
        .pkt_out    (pkt_out),
        .overflow   (overflow)
    );

endmodule

`default_nettype wire

/* src/ing_pkt_store.sv */
/* Round-robin packet store with one data partition per port; a full partition still accepts
   the word and only pulses overflow. The output has no back-pressure. */

`default_nettype none

module ing_pkt_store #(
    parameter int NUM_PORTS     = 4,
    parameter int PART_WORDS    = 16,
    parameter int PKTS_PER_PART = 8
) (
    input  logic                                    ing_bus,
    input  logic                                    arst_n,
    input  logic [NUM_PORTS-1:0]                    word_valid,
    input  ing_buf_pkg::bus_word_t [NUM_PORTS-1:0]  word,
    output logic [NUM_PORTS-1:0]                    grant,
    output ing_buf_pkg::pkt_word_t                  pkt_out,
    output logic [NUM_PORTS-1:0]                    overflow
);

    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int PTR_W  = $clog2(PART_WORDS);
    localparam int ATR_PW = (PKTS_PER_PART > 1) ? $clog2(PKTS_PER_PART) : 1;

    // Attribute slots per port rounded up so that {port, ptr} addresses them
    localparam int ATR_SLOTS = 1 << ATR_PW;

    typedef struct packed {
        logic [PTR_W-1:0]                  last_ptr;
        logic [ing_buf_pkg::BUS_BYTES-1:0] keep;
    } atr_entry_t;

    //////////////////////////////////////////////////////////////////////
    // Memories and pointers
    //////////////////////////////////////////////////////////////////////

    logic [ing_buf_pkg::BUS_BYTES-1:0][7:0] data_mem [NUM_PORTS*PART_WORDS];
    atr_entry_t                             atr_mem  [NUM_PORTS*ATR_SLOTS];

    logic [PTR_W-1:0]  wr_ptr     [NUM_PORTS];
    logic [PTR_W-1:0]  rd_ptr     [NUM_PORTS];
    logic [ATR_PW-1:0] atr_wr_ptr [NUM_PORTS];
    logic [ATR_PW-1:0] atr_rd_ptr [NUM_PORTS];

    logic [PORT_W-1:0] wr_sel;
    logic [PORT_W-1:0] rd_sel;

    //////////////////////////////////////////////////////////////////////
    // Write scheduler
    //////////////////////////////////////////////////////////////////////

    ing_buf_pkg::bus_word_t wr_word;
    logic                   wr_fire;
    logic [ATR_PW-1:0]      atr_wr_next;

    // Exactly one port is offered the store each cycle
    assign grant   = NUM_PORTS'(1) << wr_sel;
    assign wr_word = word[wr_sel];
    assign wr_fire = word_valid[wr_sel];

    assign atr_wr_next = (atr_wr_ptr[wr_sel] == ATR_PW'(PKTS_PER_PART - 1)) ?
                         '0 : atr_wr_ptr[wr_sel] + 1'b1;

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            wr_sel     <= '0;
            wr_ptr     <= '{default: '0};
            atr_wr_ptr <= '{default: '0};
            overflow   <= '0;
        end else begin
            if (wr_sel == PORT_W'(NUM_PORTS - 1)) begin
                wr_sel <= '0;
            end else begin
                wr_sel <= wr_sel + 1'b1;
            end
            overflow <= '0;
            if (wr_fire) begin
                // Partition full, the word overwrites unread data
                if (PTR_W'(wr_ptr[wr_sel] + 1'b1) == rd_ptr[wr_sel]) begin
                    overflow[wr_sel] <= 1'b1;
                end
                wr_ptr[wr_sel] <= wr_ptr[wr_sel] + 1'b1;
                if (wr_word.last) begin
                    atr_wr_ptr[wr_sel] <= atr_wr_next;
                end
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        if (wr_fire) begin
            data_mem[{wr_sel, wr_ptr[wr_sel]}] <= wr_word.data;
            // Packet end recorded with the same edge as its last word
            if (wr_word.last) begin
                atr_mem[{wr_sel, atr_wr_ptr[wr_sel]}] <= '{last_ptr: wr_ptr[wr_sel],
                                                          keep:     wr_word.keep};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read scheduler
    //////////////////////////////////////////////////////////////////////

    atr_entry_t                             atr_rd;
    logic                                   has_pkt;
    logic                                   at_last;
    logic [ATR_PW-1:0]                      atr_rd_next;
    logic                                   out_valid;
    logic                                   out_last;
    logic [ing_buf_pkg::BUS_BYTES-1:0][7:0] out_data;
    logic [ing_buf_pkg::BUS_BYTES-1:0]      out_keep;
    logic [ing_buf_pkg::PORT_IDX_BITS-1:0]  out_port;

    assign atr_rd  = atr_mem[{rd_sel, atr_rd_ptr[rd_sel]}];
    assign has_pkt = atr_rd_ptr[rd_sel] != atr_wr_ptr[rd_sel];
    assign at_last = rd_ptr[rd_sel] == atr_rd.last_ptr;

    assign atr_rd_next = (atr_rd_ptr[rd_sel] == ATR_PW'(PKTS_PER_PART - 1)) ?
                         '0 : atr_rd_ptr[rd_sel] + 1'b1;

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            rd_sel     <= '0;
            rd_ptr     <= '{default: '0};
            atr_rd_ptr <= '{default: '0};
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            // Move on when idle or right after a packet has ended
            if (!has_pkt || out_last) begin
                if (rd_sel == PORT_W'(NUM_PORTS - 1)) begin
                    rd_sel <= '0;
                end else begin
                    rd_sel <= rd_sel + 1'b1;
                end
            end else begin
                out_valid      <= 1'b1;
                rd_ptr[rd_sel] <= rd_ptr[rd_sel] + 1'b1;
                if (at_last) begin
                    out_last           <= 1'b1;
                    atr_rd_ptr[rd_sel] <= atr_rd_next;
                end
            end
        end
    end

    // Output payload, qualified by out_valid
    always_ff @(posedge ing_bus) begin
        out_data <= data_mem[{rd_sel, rd_ptr[rd_sel]}];
        out_keep <= at_last ? atr_rd.keep : '1;
        out_port <= ing_buf_pkg::PORT_IDX_BITS'(rd_sel);
    end

    assign pkt_out = '{valid: out_valid,
                       data:  out_data,
                       keep:  out_keep,
                       last:  out_last,
                       port:  out_port};

endmodule

`default_nettype wire

/* src/ing_width_adapter.sv */
/* Packs narrow beats into wide words, low lanes first, and holds a closed word until granted.
   Input is stalled while a word waits, up to one round of the store's write scheduler. */

`default_nettype none

module ing_width_adapter (
    input  logic                   ing_bus,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  ing_buf_pkg::in_beat_t  in_beat,
    output logic                   in_ready,
    input  logic                   grant,
    output logic                   word_valid,
    output ing_buf_pkg::bus_word_t word
);

    localparam int LANE_W = (ing_buf_pkg::BEATS_PER_WORD > 1) ?
                            $clog2(ing_buf_pkg::BEATS_PER_WORD) : 1;

    //////////////////////////////////////////////////////////////////////
    // Lane assembly
    //////////////////////////////////////////////////////////////////////

    logic [LANE_W-1:0]      lane;
    ing_buf_pkg::bus_word_t asm_word;
    ing_buf_pkg::bus_word_t next_word;
    logic                   accept;
    logic                   close;

    assign in_ready = ~word_valid;
    assign accept   = in_valid & in_ready;

    // Word closes on a full set of lanes or at the end of a packet
    assign close = (lane == LANE_W'(ing_buf_pkg::BEATS_PER_WORD - 1)) | in_beat.last;

    always_comb begin
        next_word = asm_word;
        next_word.data[lane*ing_buf_pkg::IN_BYTES +: ing_buf_pkg::IN_BYTES] = in_beat.data;
        next_word.keep[lane*ing_buf_pkg::IN_BYTES +: ing_buf_pkg::IN_BYTES] = in_beat.keep;
        next_word.last = in_beat.last;
    end

    //////////////////////////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            lane       <= '0;
            asm_word   <= '0;
            word_valid <= 1'b0;
        end else begin
            // Store took the held word this cycle
            if (word_valid && grant) begin
                word_valid <= 1'b0;
            end
            if (accept) begin
                if (close) begin
                    // Start the next word from empty lanes
                    lane       <= '0;
                    asm_word   <= '0;
                    word_valid <= 1'b1;
                end else begin
                    lane     <= lane + 1'b1;
                    asm_word <= next_word;
                end
            end
        end
    end

    // Holding register for the closed word
    always_ff @(posedge ing_bus) begin
        if (accept && close) begin
            word <= next_word;
        end
    end

endmodule

`default_nettype wire

/* verification/ing_buf_properties.sv */
/* Handshake and framing checks on the packet store, bound to every ing_pkt_store.
   A write counts as a grant only when the granted port also has word_valid high. */

`default_nettype none

module ing_buf_properties #(
    parameter int NUM_PORTS = 4
) (
    input logic                   ing_bus,
    input logic                   arst_n,
    input logic [NUM_PORTS-1:0]   grant,
    input logic [NUM_PORTS-1:0]   word_valid,
    input ing_buf_pkg::pkt_word_t pkt_out,
    input logic [NUM_PORTS-1:0]   overflow
);

    timeunit 1ns;
    timeprecision 1ps;

    // Write scheduler offers exactly one port and moves on by one port each cycle
    a_grant_onehot: assert property (@(posedge ing_bus) disable iff (!arst_n)
        $onehot(grant) |=> $onehot(grant) &&
            grant == (($past(grant) << 1) | ($past(grant) >> (NUM_PORTS - 1))))
        else $error("grant is not one-hot or did not rotate");

    // Read scheduler spends one idle cycle after each packet
    a_gap_after_last: assert property (@(posedge ing_bus) disable iff (!arst_n)
        (pkt_out.valid && pkt_out.last) |=> !pkt_out.valid)
        else $error("pkt_out valid right after a last word");

    // Overflow only marks a port that was written in the previous cycle
    a_overflow_needs_write: assert property (@(posedge ing_bus) disable iff (!arst_n)
        (overflow & ~$past(grant & word_valid)) == '0)
        else $error("overflow without a write to that port in the previous cycle");

endmodule

bind ing_pkt_store ing_buf_properties #(.NUM_PORTS(NUM_PORTS)) props_i (
    .ing_bus    (ing_bus),
    .arst_n     (arst_n),
    .grant      (grant),
    .word_valid (word_valid),
    .pkt_out    (pkt_out),
    .overflow   (overflow)
);

`default_nettype wire

/* verification/tb_ing_buf.sv */
/* Random multi-port traffic checked against a queue model, then one oversized packet.
   DUT outputs are sampled and inputs driven on the falling clock edge. */

`default_nettype none

module tb_ing_buf;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS       = 4;
    localparam int PART_WORDS      = 16;
    localparam int PKTS_PER_PART   = 8;
    localparam int IB              = ing_buf_pkg::IN_BYTES;
    localparam int BPW             = ing_buf_pkg::BEATS_PER_WORD;
    localparam int MAX_BEATS       = 20;
    localparam int MAX_WORDS       = (MAX_BEATS + BPW - 1) / BPW;
    localparam int NUM_PKTS        = 60;
    localparam int LONG_PORT       = 1;
    localparam int LONG_BEATS      = (PART_WORDS + 4) * BPW;
    localparam int WATCHDOG_CYCLES = NUM_PKTS * MAX_WORDS * NUM_PORTS * 2;

    logic                                  ing_bus;
    logic                                  arst_n;
    logic [NUM_PORTS-1:0]                  in_valid;
    ing_buf_pkg::in_beat_t [NUM_PORTS-1:0] in_beat;
    logic [NUM_PORTS-1:0]                  in_ready;
    ing_buf_pkg::pkt_word_t                pkt_out;
    logic [NUM_PORTS-1:0]                  overflow;

    // Reference model state
    ing_buf_pkg::pkt_word_t                exp_q [NUM_PORTS][$];
    ing_buf_pkg::pkt_word_t                asm_w [NUM_PORTS];
    int                                    lane [NUM_PORTS];
    int                                    beats_left [NUM_PORTS];
    int                                    pkts_open [NUM_PORTS];
    logic [31:0]                           rng;
    int                                    errors;
    int                                    words_checked;
    int                                    pkts_started;
    int                                    long_pulses;
    logic                                  allow_new;
    logic                                  check_out;
    logic                                  open_pkt;
    logic [ing_buf_pkg::PORT_IDX_BITS-1:0] open_port;
    logic [NUM_PORTS-1:0]                  ovf_allowed;

    ing_buf_top #(
        .NUM_PORTS     (NUM_PORTS),
        .PART_WORDS    (PART_WORDS),
        .PKTS_PER_PART (PKTS_PER_PART)
    ) dut_i (
        .ing_bus  (ing_bus),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .in_ready (in_ready),
        .pkt_out  (pkt_out),
        .overflow (overflow)
    );

    initial begin
        ing_bus = 1'b0;
        forever #50 ing_bus = ~ing_bus;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic compare_word(input ing_buf_pkg::pkt_word_t act,
                                input ing_buf_pkg::pkt_word_t expected);
        words_checked++;
        if (act !== expected) begin
            errors++;
            $display("[ERROR] %0t pkt_out: got %h expected %h", $time, act, expected);
        end
    endtask

    task automatic compare_overflow(input logic [NUM_PORTS-1:0] act,
                                    input logic [NUM_PORTS-1:0] expected);
        if (act !== expected) begin
            errors++;
            $display("[ERROR] %0t overflow: got %b expected %b", $time, act, expected);
        end
    endtask

    task automatic compare_ready(input logic [NUM_PORTS-1:0] act,
                                 input logic [NUM_PORTS-1:0] expected);
        if (act !== expected) begin
            errors++;
            $display("[ERROR] %0t in_ready: got %b expected %b", $time, act, expected);
        end
    endtask

    // Packing rule: low lanes first, close on a full word or on last
    task automatic record_beat(input int p, input ing_buf_pkg::in_beat_t b);
        asm_w[p].data[lane[p]*IB +: IB] = b.data;
        asm_w[p].keep[lane[p]*IB +: IB] = b.keep;
        if (lane[p] == BPW - 1 || b.last) begin
            asm_w[p].valid = 1'b1;
            asm_w[p].last  = b.last;
            asm_w[p].port  = ing_buf_pkg::PORT_IDX_BITS'(p);
            if (!b.last) begin
                asm_w[p].keep = '1;
            end
            exp_q[p].push_back(asm_w[p]);
            asm_w[p] = '0;
            lane[p]  = 0;
        end else begin
            lane[p]++;
        end
        if (b.last) begin
            pkts_open[p]++;
        end
    endtask

    task automatic check_outputs();
        ing_buf_pkg::pkt_word_t expected;
        int                     p;
        compare_overflow(overflow & ~ovf_allowed, '0);
        if (overflow[LONG_PORT] && ovf_allowed[LONG_PORT]) begin
            long_pulses++;
        end
        if (pkt_out.valid && check_out) begin
            p = int'(pkt_out.port);
            if (open_pkt && pkt_out.port != open_port) begin
                errors++;
                $display("Port %0d word split a packet of port %0d at %0t", p, open_port, $time);
            end
            if (p >= NUM_PORTS || exp_q[p].size() == 0) begin
                errors++;
                $display("Unexpected output word tagged port %0d at %0t", p, $time);
            end else begin
                expected = exp_q[p].pop_front();
                compare_word(pkt_out, expected);
                if (expected.last) begin
                    pkts_open[p]--;
                end
            end
            open_pkt  = !pkt_out.last;
            open_port = pkt_out.port;
        end
    endtask

    // New packets only while the partition and attribute space stay clear of full
    task automatic drive_inputs();
        logic [31:0] r;
        int          klen;
        for (int p = 0; p < NUM_PORTS; p++) begin
            r = next_random();
            if (beats_left[p] == 0 && allow_new && pkts_started < NUM_PKTS &&
                pkts_open[p] < PKTS_PER_PART - 1 &&
                exp_q[p].size() + MAX_WORDS < PART_WORDS) begin
                beats_left[p] = 1 + int'(r % MAX_BEATS);
                pkts_started++;
                r = next_random();
            end
            in_valid[p]      = (beats_left[p] > 0) && (r[31:30] != 2'b00);
            in_beat[p].data  = r[8*IB-1:0];
            in_beat[p].last  = (beats_left[p] == 1);
            klen             = 1 + int'(r[23:16]) % IB;
            in_beat[p].keep  = in_beat[p].last ? IB'((1 << klen) - 1) : '1;
            // in_ready only moves on a rising edge, so this predicts the transfer
            if (in_valid[p] && in_ready[p]) begin
                record_beat(p, in_beat[p]);
                beats_left[p]--;
            end
        end
    endtask

    function automatic logic traffic_done();
        logic done;
        done = (pkts_started >= NUM_PKTS);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (beats_left[p] != 0 || exp_q[p].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rng           = 32'hd335_96e3;
        errors        = 0;
        words_checked = 0;
        pkts_started  = 0;
        long_pulses   = 0;
        allow_new     = 1'b0;
        check_out     = 1'b1;
        open_pkt      = 1'b0;
        open_port     = '0;
        ovf_allowed   = '0;
        in_valid      = '0;
        in_beat       = '0;
        arst_n        = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            asm_w[p]      = '0;
            lane[p]       = 0;
            beats_left[p] = 0;
            pkts_open[p]  = 0;
        end
        repeat (2) @(negedge ing_bus);
        arst_n = 1'b1;

        // Quiet after reset
        repeat (8) begin
            @(negedge ing_bus);
            if (pkt_out.valid !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t pkt_out.valid: got %b expected %b",
                         $time, pkt_out.valid, 1'b0);
            end
            compare_overflow(overflow, '0);
            compare_ready(in_ready, '1);
        end

        // One beat with one byte kept
        @(negedge ing_bus);
        check_outputs();
        in_valid           = NUM_PORTS'(1) << 2;
        in_beat[2].data    = 16'h5aa5;
        in_beat[2].keep    = IB'(1);
        in_beat[2].last    = 1'b1;
        record_beat(2, in_beat[2]);
        @(negedge ing_bus);
        check_outputs();
        in_valid = '0;

        allow_new = 1'b1;
        while (!traffic_done()) begin
            @(negedge ing_bus);
            check_outputs();
            drive_inputs();
        end

        // Oversized packet, its output is corrupt by design
        allow_new             = 1'b0;
        check_out             = 1'b0;
        ovf_allowed           = NUM_PORTS'(1) << LONG_PORT;
        beats_left[LONG_PORT] = LONG_BEATS;
        while (beats_left[LONG_PORT] > 0) begin
            @(negedge ing_bus);
            check_outputs();
            drive_inputs();
        end
        repeat (4 * PART_WORDS) begin
            @(negedge ing_bus);
            check_outputs();
        end
        if (long_pulses == 0) begin
            errors++;
            $display("No overflow pulse on port %0d for a packet over %0d words",
                     LONG_PORT, PART_WORDS);
        end

        $display("Checked %0d words, saw %0d overflow pulses, counted %0d errors",
                 words_checked, long_pulses, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ing_bus);
        $display("Timeout after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
